//--- sim.f
+incdir+verilog
+incdir+sim
verilog/cent_bus_pkg.sv
verilog/cent_cab_pkg.sv
verilog/cent_bus_decode.sv
verilog/cent_cab_inputs.sv
verilog/cent_out_latch.sv
verilog/cent_earom.sv
verilog/cent_read_result.sv
verilog/cent_io_top.sv
sim/tb_cent_io.sv

//--- run_sim.sh
#!/bin/sh
# build and run the centipede i/o testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_cent_io -o tb_cent_io
./obj_dir/tb_cent_io 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

//--- sim/tb_cent_model.svh
// reference model of the output latch, the earom cells and the expected read words
`ifndef TB_CENT_MODEL_SVH
`define TB_CENT_MODEL_SVH

// latch image with flip in bit 7 and coin counters in 2..0
cent_cab_pkg::latch_bits_t exp_latch;

// earom image and its registers
cent_bus_pkg::bus_data_t ea_cells [`CENT_EAROM_DEPTH];
cent_cab_pkg::earom_addr_t ea_addr_m;
cent_bus_pkg::bus_data_t ea_data_m;
cent_bus_pkg::bus_data_t ea_out_m;
logic ea_cs_m;
logic ea_erase_m;
logic ea_write_m;

// state right after reset where cells stay unknown
function automatic void reset_model();
	exp_latch = '0;
	ea_out_m = '0;
	ea_cs_m = 1'b0;
	ea_erase_m = 1'b0;
	ea_write_m = 1'b0;
endfunction

// a[13:10] picks the block of the centipede map
// a[1] splits the inputs, a[9:7] splits the earom block
function automatic cent_bus_pkg::io_region_e region_of(input cent_bus_pkg::bus_addr_t a);
	logic [3:0] blk;
	logic [2:0] sub;
	cent_bus_pkg::io_region_e r;
	blk = a[13:10];
	sub = a[9:7];
	r = cent_bus_pkg::NONE;
	if (blk == 4'(`CENT_OFS_SWITCH >> 10))
		r = cent_bus_pkg::SWITCH;
	else if (blk == 4'(`CENT_OFS_INPUT >> 10))
		r = a[1] ? cent_bus_pkg::JOYSTICK : cent_bus_pkg::PLAYER;
	else if (blk == 4'(`CENT_OFS_OUTLATCH >> 10))
		r = cent_bus_pkg::OUTLATCH;
	else if (blk == 4'(`CENT_OFS_EAROM_RD >> 10))
	begin
		if (sub == 3'(`CENT_OFS_EAROM_RD >> 7))
			r = cent_bus_pkg::EAROM_RD;
		else if (sub == 3'(`CENT_OFS_EAROM_CTRL >> 7))
			r = cent_bus_pkg::EAROM_CTRL;
		else if (sub == 3'(`CENT_OFS_EAROM_ADDR >> 7))
			r = cent_bus_pkg::EAROM_ADDR;
	end
	return r;
endfunction

// earom keeps acting on its control every cycle
function automatic void settle_earom();
	if (ea_cs_m && ea_write_m)
		ea_cells[ea_addr_m] = ea_erase_m ? 8'h00 : ea_data_m;
	else if (ea_cs_m)
		ea_out_m = ea_cells[ea_addr_m];
endfunction

// effect of one accepted write
function automatic void note_write(input cent_bus_pkg::bus_addr_t a,
	input cent_bus_pkg::bus_data_t d);
	case (region_of(a))
		cent_bus_pkg::OUTLATCH:
			exp_latch[a[2:0]] = d[7];
		cent_bus_pkg::EAROM_ADDR:
		begin
			ea_addr_m = a[5:0];
			ea_data_m = d;
		end
		cent_bus_pkg::EAROM_CTRL:
		begin
			// a one in d1 means write
			ea_cs_m = d[3];
			ea_erase_m = d[2];
			ea_write_m = d[1];
		end
		default:
			;
	endcase
	settle_earom();
endfunction

// raw player bits coin_r coin_c coin_l self_test cocktail slam start2 start1 fire2 fire1
function automatic cent_bus_pkg::bus_data_t expected_read(input cent_bus_pkg::bus_addr_t a);
	logic coin_r;
	logic coin_c;
	logic coin_l;
	cent_bus_pkg::bus_data_t w;
	// a running coin counter forces its coin switch
	coin_r = player[9] | exp_latch[2];
	coin_c = player[8] | exp_latch[1];
	coin_l = player[7] | exp_latch[0];
	w = 8'h00;
	case (region_of(a))
		cent_bus_pkg::SWITCH:
			w = a[0] ? sw2 : sw1;
		cent_bus_pkg::PLAYER:
		begin
			if (a[0])
				w = {coin_r, coin_c, coin_l, player[4], player[1], player[0], player[3],
					player[2]};
			else
				w = {1'b0, vblank, player[6], player[5], 4'h0};
		end
		cent_bus_pkg::JOYSTICK:
			w = a[0] ? joy : 8'h00;
		cent_bus_pkg::EAROM_RD:
			w = ea_out_m;
		default:
			w = 8'h00;
	endcase
	return w;
endfunction

`endif

//--- sim/tb_cent_io.sv
// testbench for the centipede cabinet i/o slave with random axi traffic checked against a model
`include "centipede_io_cfg.svh"

module tb_cent_io;

	// longest wait on any handshake in cycles
	localparam int WAIT_LIMIT = 32;

	// which handshake a wait loop watches
	localparam int SEL_AWREADY = 0;
	localparam int SEL_BVALID = 1;
	localparam int SEL_ARREADY = 2;
	localparam int SEL_RVALID = 3;

	localparam cent_bus_pkg::bus_addr_t A_SWITCH = `CENT_OFS_SWITCH;
	localparam cent_bus_pkg::bus_addr_t A_INPUT = `CENT_OFS_INPUT;
	localparam cent_bus_pkg::bus_addr_t A_EAROM_RD = `CENT_OFS_EAROM_RD;
	localparam cent_bus_pkg::bus_addr_t A_EAROM_CTRL = `CENT_OFS_EAROM_CTRL;
	localparam cent_bus_pkg::bus_addr_t A_EAROM_ADDR = `CENT_OFS_EAROM_ADDR;
	localparam cent_bus_pkg::bus_addr_t A_OUTLATCH = `CENT_OFS_OUTLATCH;
	localparam cent_bus_pkg::bus_resp_t OKAY = 2'b00;

	// ram, pokey, lower earom block, irq ack, high space, plus write-only regions
	localparam cent_bus_pkg::bus_addr_t NO_READ_ADDRS [9] = '{14'h0000, 14'h0400, 14'h1000,
		14'h1400, 14'h1780, 14'h1800, 14'h3FFF, 14'h1C00, 14'h1680};

	logic s_6mhz;
	logic reset;
	logic awvalid;
	logic awready;
	cent_bus_pkg::bus_addr_t awaddr;
	logic wvalid;
	logic wready;
	cent_bus_pkg::bus_data_t wdata;
	logic bvalid;
	logic bready;
	cent_bus_pkg::bus_resp_t bresp;
	logic arvalid;
	logic arready;
	cent_bus_pkg::bus_addr_t araddr;
	logic rvalid;
	logic rready;
	cent_bus_pkg::bus_data_t rdata;
	cent_bus_pkg::bus_resp_t rresp;
	cent_cab_pkg::switch_bank_t sw1;
	cent_cab_pkg::switch_bank_t sw2;
	cent_cab_pkg::player_in_t player;
	logic [7:0] joy;
	logic vblank;
	logic flip;
	logic [4:1] led;
	logic [2:0] coin_ctr;

	logic [31:0] rng_state;
	// earom cells with known contents
	cent_cab_pkg::earom_addr_t stored_q[$];

	`include "tb_cent_model.svh"

	cent_io_top cent_io_top_inst (
		.s_6mhz          (s_6mhz),
		.reset           (reset),
		.s_axi_awvalid_i (awvalid),
		.s_axi_awready_o (awready),
		.s_axi_awaddr_i  (awaddr),
		.s_axi_wvalid_i  (wvalid),
		.s_axi_wready_o  (wready),
		.s_axi_wdata_i   (wdata),
		.s_axi_bvalid_o  (bvalid),
		.s_axi_bready_i  (bready),
		.s_axi_bresp_o   (bresp),
		.s_axi_arvalid_i (arvalid),
		.s_axi_arready_o (arready),
		.s_axi_araddr_i  (araddr),
		.s_axi_rvalid_o  (rvalid),
		.s_axi_rready_i  (rready),
		.s_axi_rdata_o   (rdata),
		.s_axi_rresp_o   (rresp),
		.sw1_i           (sw1),
		.sw2_i           (sw2),
		.playerinput_i   (player),
		.joystick_i      (joy),
		.vblank_i        (vblank),
		.flip_o          (flip),
		.led_o           (led),
		.coin_ctr_o      (coin_ctr)
	);

	// 40 unit period
	always #20 s_6mhz = ~s_6mhz;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// random address inside a region where the mask keeps the free bits
	function automatic cent_bus_pkg::bus_addr_t pick_addr(input cent_bus_pkg::bus_addr_t base,
		input cent_bus_pkg::bus_addr_t free_bits);
		logic [31:0] r;
		r = next_rand();
		return base | (r[13:0] & free_bits);
	endfunction

	function automatic cent_bus_pkg::bus_addr_t pick_readable();
		logic [31:0] r;
		cent_bus_pkg::bus_addr_t a;
		r = next_rand();
		case (r[1:0])
			2'd0: a = pick_addr(A_SWITCH, 14'h03FF);
			2'd1: a = pick_addr(A_INPUT, 14'h03FD);
			2'd2: a = pick_addr(A_INPUT, 14'h03FF) | 14'h0002;
			default: a = pick_addr(A_EAROM_RD, 14'h007F);
		endcase
		return a;
	endfunction

	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_data(input string name, input cent_bus_pkg::bus_data_t got,
		input cent_bus_pkg::bus_data_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_resp(input string name, input cent_bus_pkg::bus_resp_t got,
		input cent_bus_pkg::bus_resp_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// flip, leds and coin counters side by side
	task automatic check_latch(input cent_cab_pkg::latch_bits_t got,
		input cent_cab_pkg::latch_bits_t exp);
		if (got !== exp)
		begin
			$display("FAILED flip_o/led_o/coin_ctr_o got 0x%h expected 0x%h", got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	function automatic logic handshake_level(input int which);
		logic v;
		case (which)
			SEL_AWREADY: v = awready;
			SEL_BVALID: v = bvalid;
			SEL_ARREADY: v = arready;
			default: v = rvalid;
		endcase
		return v;
	endfunction

	// polled on falling edges where outputs are settled
	task automatic wait_for_high(input int which, input string what);
		int n;
		n = 0;
		while (handshake_level(which) !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge s_6mhz);
			n = n + 1;
		end
		if (handshake_level(which) !== 1'b1)
		begin
			$display("timeout: %s did not rise within %0d cycles", what, WAIT_LIMIT);
			stop_with_failure();
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge s_6mhz);
	endtask

	task automatic start_write(input cent_bus_pkg::bus_addr_t a,
		input cent_bus_pkg::bus_data_t d);
		awaddr = a;
		wdata = d;
		awvalid = 1'b1;
		wvalid = 1'b1;
	endtask

	// ready seen here so the next rising edge accepts
	task automatic finish_write();
		wait_for_high(SEL_AWREADY, "awready");
		check_flag("wready", wready, 1'b1);
		@(negedge s_6mhz);
		awvalid = 1'b0;
		wvalid = 1'b0;
		wait_for_high(SEL_BVALID, "bvalid");
	endtask

	task automatic take_bresp();
		check_resp("bresp", bresp, OKAY);
		bready = 1'b1;
		@(negedge s_6mhz);
		bready = 1'b0;
		check_flag("bvalid", bvalid, 1'b0);
	endtask

	task automatic write_reg(input cent_bus_pkg::bus_addr_t a,
		input cent_bus_pkg::bus_data_t d);
		start_write(a, d);
		finish_write();
		note_write(a, d);
		check_latch({flip, led, coin_ctr}, exp_latch);
		take_bresp();
	endtask

	task automatic start_read(input cent_bus_pkg::bus_addr_t a);
		araddr = a;
		arvalid = 1'b1;
	endtask

	task automatic finish_read(output cent_bus_pkg::bus_data_t d);
		wait_for_high(SEL_ARREADY, "arready");
		@(negedge s_6mhz);
		arvalid = 1'b0;
		wait_for_high(SEL_RVALID, "rvalid");
		d = rdata;
	endtask

	task automatic take_rdata();
		check_resp("rresp", rresp, OKAY);
		rready = 1'b1;
		@(negedge s_6mhz);
		rready = 1'b0;
		check_flag("rvalid", rvalid, 1'b0);
	endtask

	task automatic read_check(input cent_bus_pkg::bus_addr_t a);
		cent_bus_pkg::bus_data_t exp;
		cent_bus_pkg::bus_data_t got;
		exp = expected_read(a);
		start_read(a);
		finish_read(got);
		check_data("rdata", got, exp);
		take_rdata();
	endtask

	// new cabinet values then long enough for the synchronizers
	task automatic set_inputs();
		logic [31:0] r;
		r = next_rand();
		sw1 = r[7:0];
		sw2 = r[15:8];
		player = r[25:16];
		vblank = r[26];
		r = next_rand();
		joy = r[7:0];
		idle(4);
	endtask

	// address, write, then back to read select
	task automatic earom_store(input cent_cab_pkg::earom_addr_t ea,
		input cent_bus_pkg::bus_data_t d);
		write_reg(A_EAROM_ADDR | {8'h00, ea}, d);
		write_reg(A_EAROM_CTRL, 8'h0A);
		write_reg(A_EAROM_CTRL, 8'h08);
		stored_q.push_back(ea);
	endtask

	// latched data is nonzero and erase must still leave zero
	task automatic earom_erase(input cent_cab_pkg::earom_addr_t ea);
		logic [31:0] r;
		r = next_rand();
		write_reg(A_EAROM_ADDR | {8'h00, ea}, r[7:0] | 8'h01);
		write_reg(A_EAROM_CTRL, 8'h0E);
		write_reg(A_EAROM_CTRL, 8'h08);
	endtask

	// read select stays on so an address write moves the read register
	task automatic earom_readback(input cent_cab_pkg::earom_addr_t ea);
		logic [31:0] r;
		r = next_rand();
		write_reg(A_EAROM_ADDR | {8'h00, ea}, r[7:0]);
		idle(2);
		read_check(pick_addr(A_EAROM_RD, 14'h007F));
	endtask

	initial
	begin
		logic [31:0] r;
		cent_bus_pkg::bus_addr_t a;
		cent_bus_pkg::bus_addr_t a2;
		cent_bus_pkg::bus_data_t d2;
		cent_bus_pkg::bus_data_t exp1;
		cent_bus_pkg::bus_data_t got;
		int hold;

		s_6mhz = 1'b0;
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		sw1 = '0;
		sw2 = '0;
		player = '0;
		joy = '0;
		vblank = 1'b0;
		rng_state = 32'h92a3;
		reset_model();
		idle(2);
		reset = 1'b0;

		// quiet bus and cleared outputs after reset
		check_flag("awready", awready, 1'b0);
		check_flag("wready", wready, 1'b0);
		check_flag("arready", arready, 1'b0);
		check_flag("bvalid", bvalid, 1'b0);
		check_flag("rvalid", rvalid, 1'b0);
		check_latch({flip, led, coin_ctr}, 8'h00);
		read_check(A_EAROM_RD);

		// random output latch writes
		repeat (24)
		begin
			r = next_rand();
			write_reg(pick_addr(A_OUTLATCH, 14'h03FF), r[7:0]);
		end

		// switches, player words and joystick with coin bits under counter drive
		repeat (12)
		begin
			set_inputs();
			r = next_rand();
			write_reg(A_OUTLATCH | {12'h000, r[1:0]}, r[15:8]);
			a = pick_addr(A_SWITCH, 14'h03FE);
			read_check(a);
			read_check(a | 14'h0001);
			a = pick_addr(A_INPUT, 14'h03FC);
			read_check(a);
			read_check(a | 14'h0001);
			read_check(a | 14'h0002);
			read_check(a | 14'h0003);
		end

		// earom write, erase and random readback
		earom_store(6'h15, 8'hA5);
		earom_readback(6'h15);
		earom_erase(6'h15);
		earom_readback(6'h15);
		repeat (16)
		begin
			r = next_rand();
			earom_store(r[5:0], r[15:8]);
			earom_readback(r[5:0]);
			r = next_rand();
			earom_readback(stored_q[r % stored_q.size()]);
		end
		foreach (stored_q[i])
			earom_readback(stored_q[i]);

		// write response held while a second write waits
		repeat (6)
		begin
			a = pick_addr(A_OUTLATCH, 14'h03FF);
			r = next_rand();
			start_write(a, r[7:0]);
			finish_write();
			note_write(a, r[7:0]);
			a2 = pick_addr(A_OUTLATCH, 14'h03FF);
			r = next_rand();
			d2 = r[7:0];
			hold = 1 + int'(r[10:8]);
			start_write(a2, d2);
			repeat (hold)
			begin
				@(negedge s_6mhz);
				check_flag("bvalid", bvalid, 1'b1);
				check_resp("bresp", bresp, OKAY);
				check_flag("awready", awready, 1'b0);
				check_latch({flip, led, coin_ctr}, exp_latch);
			end
			take_bresp();
			finish_write();
			note_write(a2, d2);
			check_latch({flip, led, coin_ctr}, exp_latch);
			take_bresp();
		end

		// read data held while a second read waits
		repeat (6)
		begin
			a = pick_readable();
			exp1 = expected_read(a);
			start_read(a);
			finish_read(got);
			check_data("rdata", got, exp1);
			a2 = pick_readable();
			d2 = expected_read(a2);
			r = next_rand();
			hold = 1 + int'(r[2:0]);
			start_read(a2);
			repeat (hold)
			begin
				@(negedge s_6mhz);
				check_flag("rvalid", rvalid, 1'b1);
				check_flag("arready", arready, 1'b0);
				check_data("rdata", rdata, exp1);
			end
			take_rdata();
			finish_read(got);
			check_data("rdata", got, d2);
			take_rdata();
		end

		// unmapped and write-only addresses read zero
		foreach (NO_READ_ADDRS[i])
			read_check(NO_READ_ADDRS[i]);

		idle(2);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- verilog/cent_io_top.sv
// centipede cabinet i/o as an axi4-lite slave
`include "centipede_io_cfg.svh"

module cent_io_top (
	input  logic                          s_6mhz,
	input  logic                          reset,
	input  logic                          s_axi_awvalid_i,
	output logic                          s_axi_awready_o,
	input  cent_bus_pkg::bus_addr_t       s_axi_awaddr_i,
	input  logic                          s_axi_wvalid_i,
	output logic                          s_axi_wready_o,
	input  cent_bus_pkg::bus_data_t       s_axi_wdata_i,
	output logic                          s_axi_bvalid_o,
	input  logic                          s_axi_bready_i,
	output cent_bus_pkg::bus_resp_t       s_axi_bresp_o,
	input  logic                          s_axi_arvalid_i,
	output logic                          s_axi_arready_o,
	input  cent_bus_pkg::bus_addr_t       s_axi_araddr_i,
	output logic                          s_axi_rvalid_o,
	input  logic                          s_axi_rready_i,
	output cent_bus_pkg::bus_data_t       s_axi_rdata_o,
	output cent_bus_pkg::bus_resp_t       s_axi_rresp_o,
	input  cent_cab_pkg::switch_bank_t    sw1_i,
	input  cent_cab_pkg::switch_bank_t    sw2_i,
	input  cent_cab_pkg::player_in_t      playerinput_i,
	input  logic [`CENT_DATA_W-1:0]       joystick_i,
	input  logic                          vblank_i,
	output logic                          flip_o,
	output logic [`CENT_LED_W:1]          led_o,
	output logic [`CENT_COIN_W-1:0]       coin_ctr_o
);

	// decode to execute
	logic wr_stb;
	cent_bus_pkg::io_region_e wr_region;
	cent_bus_pkg::bus_addr_t wr_addr;
	cent_bus_pkg::bus_data_t wr_data;
	logic rd_stb;
	cent_bus_pkg::io_region_e rd_region;
	cent_bus_pkg::bus_addr_t rd_addr;

	// execute to result
	cent_bus_pkg::bus_data_t switch_word;
	cent_bus_pkg::bus_data_t player_word;
	cent_bus_pkg::bus_data_t joy_word;
	cent_bus_pkg::bus_data_t earom_word;

	cent_bus_decode cent_bus_decode_inst (
		.s_6mhz          (s_6mhz),
		.reset           (reset),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.bvalid_i        (s_axi_bvalid_o),
		.rvalid_i        (s_axi_rvalid_o),
		.wr_stb_o        (wr_stb),
		.wr_region_o     (wr_region),
		.wr_addr_o       (wr_addr),
		.wr_data_o       (wr_data),
		.rd_stb_o        (rd_stb),
		.rd_region_o     (rd_region),
		.rd_addr_o       (rd_addr)
	);

	// coin counters loop back into the coin inputs
	cent_cab_inputs cent_cab_inputs_inst (
		.s_6mhz        (s_6mhz),
		.reset         (reset),
		.sw1_i         (sw1_i),
		.sw2_i         (sw2_i),
		.playerinput_i (playerinput_i),
		.joystick_i    (joystick_i),
		.vblank_i      (vblank_i),
		.coin_drive_i  (coin_ctr_o),
		.rd_addr_i     (rd_addr),
		.switch_word_o (switch_word),
		.player_word_o (player_word),
		.joy_word_o    (joy_word)
	);

	cent_out_latch cent_out_latch_inst (
		.s_6mhz      (s_6mhz),
		.reset       (reset),
		.wr_stb_i    (wr_stb),
		.wr_region_i (wr_region),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.flip_o      (flip_o),
		.led_o       (led_o),
		.coin_ctr_o  (coin_ctr_o)
	);

	cent_earom cent_earom_inst (
		.s_6mhz       (s_6mhz),
		.reset        (reset),
		.wr_stb_i     (wr_stb),
		.wr_region_i  (wr_region),
		.wr_addr_i    (wr_addr),
		.wr_data_i    (wr_data),
		.earom_word_o (earom_word)
	);

	cent_read_result cent_read_result_inst (
		.s_6mhz        (s_6mhz),
		.reset         (reset),
		.rd_stb_i      (rd_stb),
		.rd_region_i   (rd_region),
		.wr_stb_i      (wr_stb),
		.switch_word_i (switch_word),
		.player_word_i (player_word),
		.joy_word_i    (joy_word),
		.earom_word_i  (earom_word),
		.rvalid_o      (s_axi_rvalid_o),
		.rready_i      (s_axi_rready_i),
		.rdata_o       (s_axi_rdata_o),
		.rresp_o       (s_axi_rresp_o),
		.bvalid_o      (s_axi_bvalid_o),
		.bready_i      (s_axi_bready_i),
		.bresp_o       (s_axi_bresp_o)
	);

endmodule

//--- verilog/cent_read_result.sv
// read data select and axi read/write response holding
module cent_read_result (
	input  logic                        s_6mhz,
	input  logic                        reset,
	input  logic                        rd_stb_i,
	input  cent_bus_pkg::io_region_e    rd_region_i,
	input  logic                        wr_stb_i,
	input  cent_bus_pkg::bus_data_t     switch_word_i,
	input  cent_bus_pkg::bus_data_t     player_word_i,
	input  cent_bus_pkg::bus_data_t     joy_word_i,
	input  cent_bus_pkg::bus_data_t     earom_word_i,
	output logic                        rvalid_o,
	input  logic                        rready_i,
	output cent_bus_pkg::bus_data_t     rdata_o,
	output cent_bus_pkg::bus_resp_t     rresp_o,
	output logic                        bvalid_o,
	input  logic                        bready_i,
	output cent_bus_pkg::bus_resp_t     bresp_o
);

	cent_bus_pkg::bus_data_t rd_sel;
	cent_bus_pkg::bus_data_t rdata_q;
	logic rvalid_q;
	logic bvalid_q;

	// word of the decoded region
	// unmapped and write-only regions read zero
	always_comb
	begin
		case (rd_region_i)
			cent_bus_pkg::SWITCH:   rd_sel = switch_word_i;
			cent_bus_pkg::PLAYER:   rd_sel = player_word_i;
			cent_bus_pkg::JOYSTICK: rd_sel = joy_word_i;
			cent_bus_pkg::EAROM_RD: rd_sel = earom_word_i;
			default:                rd_sel = '0;
		endcase
	end

	// data frozen at the accept edge
	always_ff @(posedge s_6mhz)
	begin
		if (rd_stb_i)
			rdata_q <= rd_sel;
	end

	// valids held until the master takes them
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end
		else
		begin
			if (rd_stb_i)
				rvalid_q <= 1'b1;
			else if (rready_i)
				rvalid_q <= 1'b0;
			if (wr_stb_i)
				bvalid_q <= 1'b1;
			else if (bready_i)
				bvalid_q <= 1'b0;
		end
	end

	assign rvalid_o = rvalid_q;
	assign rdata_o = rdata_q;
	assign bvalid_o = bvalid_q;

	// no error paths
	assign rresp_o = cent_bus_pkg::RESP_OKAY;
	assign bresp_o = cent_bus_pkg::RESP_OKAY;

endmodule

//--- verilog/cent_earom.sv
// high score earom: address/data latch, control register and 64x8 cells
`include "centipede_io_cfg.svh"

module cent_earom (
	input  logic                        s_6mhz,
	input  logic                        reset,
	input  logic                        wr_stb_i,
	input  cent_bus_pkg::io_region_e    wr_region_i,
	input  cent_bus_pkg::bus_addr_t     wr_addr_i,
	input  cent_bus_pkg::bus_data_t     wr_data_i,
	output cent_bus_pkg::bus_data_t     earom_word_o
);

	cent_cab_pkg::earom_addr_t ea_addr_q;
	cent_bus_pkg::bus_data_t ea_din_q;
	cent_cab_pkg::earom_ctrl_t ea_ctrl_q;
	cent_bus_pkg::bus_data_t ea_dout_q;
	cent_bus_pkg::bus_data_t ea_mem [`CENT_EAROM_DEPTH];
	logic ea_sel;
	logic ea_wr;

	// chip select, write is active low in the register
	assign ea_sel = ea_ctrl_q[cent_cab_pkg::CTRL_CS1];
	assign ea_wr = ~ea_ctrl_q[cent_cab_pkg::CTRL_WR_N];

	// cell address comes from the bus address, data from the bus data
	always_ff @(posedge s_6mhz)
	begin
		if (wr_stb_i && (wr_region_i == cent_bus_pkg::EAROM_ADDR))
		begin
			ea_addr_q <= wr_addr_i[`CENT_EAROM_AW-1:0];
			ea_din_q <= wr_data_i;
		end
	end

	// d1 inverted on the way in, so a zero there means write
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			ea_ctrl_q <= cent_cab_pkg::CTRL_RESET;
		else if (wr_stb_i && (wr_region_i == cent_bus_pkg::EAROM_CTRL))
			ea_ctrl_q <= {wr_data_i[3], wr_data_i[2], ~wr_data_i[1], wr_data_i[0]};
	end

	// write or erase repeats every cycle while selected
	always_ff @(posedge s_6mhz)
	begin
		if (ea_sel && ea_wr)
			ea_mem[ea_addr_q] <= ea_ctrl_q[cent_cab_pkg::CTRL_ERASE] ? '0 : ea_din_q;
	end

	// read register follows the cell while selected for read
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			ea_dout_q <= '0;
		else if (ea_sel && !ea_wr)
			ea_dout_q <= ea_mem[ea_addr_q];
	end

	assign earom_word_o = ea_dout_q;

endmodule

//--- verilog/cent_out_latch.sv
// addressable output latch for flip, start leds and coin counters
`include "centipede_io_cfg.svh"

module cent_out_latch (
	input  logic                        s_6mhz,
	input  logic                        reset,
	input  logic                        wr_stb_i,
	input  cent_bus_pkg::io_region_e    wr_region_i,
	input  cent_bus_pkg::bus_addr_t     wr_addr_i,
	input  cent_bus_pkg::bus_data_t     wr_data_i,
	output logic                        flip_o,
	output logic [`CENT_LED_W:1]        led_o,
	output logic [`CENT_COIN_W-1:0]     coin_ctr_o
);

	cent_cab_pkg::latch_bits_t latch_q;
	logic latch_wr;

	assign latch_wr = wr_stb_i && (wr_region_i == cent_bus_pkg::OUTLATCH);

	// one bit per address, a[2:0] picks it, d7 is the value
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			latch_q <= '0;
		else if (latch_wr)
			latch_q[wr_addr_i[2:0]] <= wr_data_i[7];
	end

	// bit 7 flips the screen
	assign flip_o = latch_q[7];

	// bits 6..3 are the four leds
	assign led_o = latch_q[6:3];

	// r, c, l coin counters
	// also looped back into the coin inputs
	assign coin_ctr_o = latch_q[2:0];

endmodule

//--- verilog/cent_cab_inputs.sv
// cabinet input synchronizers and switch, player and joystick read words
`include "centipede_io_cfg.svh"

module cent_cab_inputs (
	input  logic                          s_6mhz,
	input  logic                          reset,
	input  cent_cab_pkg::switch_bank_t    sw1_i,
	input  cent_cab_pkg::switch_bank_t    sw2_i,
	input  cent_cab_pkg::player_in_t      playerinput_i,
	input  logic [`CENT_DATA_W-1:0]       joystick_i,
	input  logic                          vblank_i,
	input  logic [`CENT_COIN_W-1:0]       coin_drive_i,
	input  cent_bus_pkg::bus_addr_t       rd_addr_i,
	output cent_bus_pkg::bus_data_t       switch_word_o,
	output cent_bus_pkg::bus_data_t       player_word_o,
	output cent_bus_pkg::bus_data_t       joy_word_o
);

	// all async inputs travel through one two-stage synchronizer
	localparam int SYNC_W = 2 * `CENT_SW_W + `CENT_PLAYER_W + `CENT_DATA_W + 1;

	logic [SYNC_W-1:0] sync_q1;
	logic [SYNC_W-1:0] sync_q2;
	cent_cab_pkg::switch_bank_t sw1_s;
	cent_cab_pkg::switch_bank_t sw2_s;
	cent_cab_pkg::player_in_t player_s;
	logic [`CENT_DATA_W-1:0] joy_s;
	logic vblank_s;
	logic coin_r;
	logic coin_c;
	logic coin_l;
	cent_bus_pkg::bus_data_t player_hi;
	cent_bus_pkg::bus_data_t player_lo;

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end
		else
		begin
			sync_q1 <= {sw1_i, sw2_i, playerinput_i, joystick_i, vblank_i};
			sync_q2 <= sync_q1;
		end
	end

	assign {sw1_s, sw2_s, player_s, joy_s, vblank_s} = sync_q2;

	// option banks, a0 picks sw2
	assign switch_word_o = rd_addr_i[0] ? sw2_s : sw1_s;

	// coin counter drive forces the coin inputs high
	assign coin_r = player_s[9] | coin_drive_i[2];
	assign coin_c = player_s[8] | coin_drive_i[1];
	assign coin_l = player_s[7] | coin_drive_i[0];

	// high word: coins, slam, fire, start
	assign player_hi = {coin_r, coin_c, coin_l, player_s[4], player_s[1], player_s[0],
		player_s[3], player_s[2]};
	// low word, trackball dir and count read as zero
	assign player_lo = {1'b0, vblank_s, player_s[6], player_s[5], 4'b0000};
	assign player_word_o = rd_addr_i[0] ? player_hi : player_lo;

	// p1 r/l/d/u then p2 r/l/d/u, even address is trackball and reads zero
	assign joy_word_o = rd_addr_i[0] ? joy_s : '0;

endmodule

//--- verilog/cent_bus_decode.sv
// axi4-lite accept logic and centipede address decode into strobes and regions
`include "centipede_io_cfg.svh"

module cent_bus_decode (
	input  logic                        s_6mhz,
	input  logic                        reset,
	input  logic                        s_axi_awvalid_i,
	output logic                        s_axi_awready_o,
	input  cent_bus_pkg::bus_addr_t     s_axi_awaddr_i,
	input  logic                        s_axi_wvalid_i,
	output logic                        s_axi_wready_o,
	input  cent_bus_pkg::bus_data_t     s_axi_wdata_i,
	input  logic                        s_axi_arvalid_i,
	output logic                        s_axi_arready_o,
	input  cent_bus_pkg::bus_addr_t     s_axi_araddr_i,
	input  logic                        bvalid_i,
	input  logic                        rvalid_i,
	output logic                        wr_stb_o,
	output cent_bus_pkg::io_region_e    wr_region_o,
	output cent_bus_pkg::bus_addr_t     wr_addr_o,
	output cent_bus_pkg::bus_data_t     wr_data_o,
	output logic                        rd_stb_o,
	output cent_bus_pkg::io_region_e    rd_region_o,
	output cent_bus_pkg::bus_addr_t     rd_addr_o
);

	localparam cent_bus_pkg::bus_addr_t OFS_SWITCH = `CENT_OFS_SWITCH;
	localparam cent_bus_pkg::bus_addr_t OFS_INPUT = `CENT_OFS_INPUT;
	localparam cent_bus_pkg::bus_addr_t OFS_EAROM_RD = `CENT_OFS_EAROM_RD;
	localparam cent_bus_pkg::bus_addr_t OFS_EAROM_CTRL = `CENT_OFS_EAROM_CTRL;
	localparam cent_bus_pkg::bus_addr_t OFS_EAROM_ADDR = `CENT_OFS_EAROM_ADDR;
	localparam cent_bus_pkg::bus_addr_t OFS_OUTLATCH = `CENT_OFS_OUTLATCH;

	logic wr_acc_q;
	logic rd_acc_q;
	logic wr_go;
	logic rd_go;
	cent_bus_pkg::io_region_e wr_region_q;
	cent_bus_pkg::io_region_e rd_region_q;
	cent_bus_pkg::bus_addr_t wr_addr_q;
	cent_bus_pkg::bus_addr_t rd_addr_q;
	cent_bus_pkg::bus_data_t wr_data_q;

	// block select on a[13:10], inputs split on a[1], earom on a[9:7]
	function automatic cent_bus_pkg::io_region_e decode_region(input cent_bus_pkg::bus_addr_t a);
		cent_bus_pkg::io_region_e r;
		r = cent_bus_pkg::NONE;
		if (a[13:10] == OFS_SWITCH[13:10])
			r = cent_bus_pkg::SWITCH;
		else if (a[13:10] == OFS_INPUT[13:10])
			r = a[1] ? cent_bus_pkg::JOYSTICK : cent_bus_pkg::PLAYER;
		else if (a[13:10] == OFS_EAROM_RD[13:10])
		begin
			// lower half of this block held colour ram, now unmapped
			if (a[9:7] == OFS_EAROM_RD[9:7])
				r = cent_bus_pkg::EAROM_RD;
			else if (a[9:7] == OFS_EAROM_CTRL[9:7])
				r = cent_bus_pkg::EAROM_CTRL;
			else if (a[9:7] == OFS_EAROM_ADDR[9:7])
				r = cent_bus_pkg::EAROM_ADDR;
		end
		else if (a[13:10] == OFS_OUTLATCH[13:10])
			r = cent_bus_pkg::OUTLATCH;
		return r;
	endfunction

	// master holds valids and payload, so sample a cycle ahead of the handshake
	assign wr_go = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_i & ~wr_acc_q;
	assign rd_go = s_axi_arvalid_i & ~rvalid_i & ~rd_acc_q;

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			wr_acc_q <= 1'b0;
			rd_acc_q <= 1'b0;
		end
		else
		begin
			wr_acc_q <= wr_go;
			rd_acc_q <= rd_go;
		end
	end

	// payload captured with the ready, valid during the accept cycle
	always_ff @(posedge s_6mhz)
	begin
		if (wr_go)
		begin
			wr_region_q <= decode_region(s_axi_awaddr_i);
			wr_addr_q <= s_axi_awaddr_i;
			wr_data_q <= s_axi_wdata_i;
		end
		if (rd_go)
		begin
			rd_region_q <= decode_region(s_axi_araddr_i);
			rd_addr_q <= s_axi_araddr_i;
		end
	end

	// readies double as the execute strobes
	assign s_axi_awready_o = wr_acc_q;
	assign s_axi_wready_o = wr_acc_q;
	assign s_axi_arready_o = rd_acc_q;
	assign wr_stb_o = wr_acc_q;
	assign wr_region_o = wr_region_q;
	assign wr_addr_o = wr_addr_q;
	assign wr_data_o = wr_data_q;
	assign rd_stb_o = rd_acc_q;
	assign rd_region_o = rd_region_q;
	assign rd_addr_o = rd_addr_q;

endmodule

//--- verilog/cent_cab_pkg.sv
// cabinet side types: option switches, player inputs, output latch, earom control
`include "centipede_io_cfg.svh"

package cent_cab_pkg;

	// one option switch bank
	typedef logic [`CENT_SW_W-1:0] switch_bank_t;

	// raw buttons, coin_r in bit 9 down to fire1 in bit 0
	typedef logic [`CENT_PLAYER_W-1:0] player_in_t;

	// addressable output latch
	// flip, leds 4..1, coin counters r/c/l
	typedef logic [`CENT_DATA_W-1:0] latch_bits_t;

	// earom cell address
	typedef logic [`CENT_EAROM_AW-1:0] earom_addr_t;

	// earom control, bit 0 is a spare
	typedef logic [`CENT_EAROM_CTRL_W-1:0] earom_ctrl_t;

	// control bit positions
	localparam int CTRL_CS1 = 3;
	localparam int CTRL_ERASE = 2;
	localparam int CTRL_WR_N = 1;

	// deselected, not writing
	localparam earom_ctrl_t CTRL_RESET = 4'b0010;

endpackage

//--- verilog/cent_bus_pkg.sv
// bus side types for the centipede i/o slave: address, data, response, region
`include "centipede_io_cfg.svh"

package cent_bus_pkg;

	// cpu address, 14 bits as on the original board
	typedef logic [`CENT_ADDR_W-1:0] bus_addr_t;

	// byte wide data path
	typedef logic [`CENT_DATA_W-1:0] bus_data_t;

	// axi response code
	typedef logic [`CENT_RESP_W-1:0] bus_resp_t;

	// slave only ever answers okay
	localparam bus_resp_t RESP_OKAY = 2'b00;

	// decoded target of an access
	typedef enum logic [2:0]
	{
		NONE,
		SWITCH,
		PLAYER,
		JOYSTICK,
		EAROM_RD,
		EAROM_CTRL,
		EAROM_ADDR,
		OUTLATCH
	} io_region_e;

endpackage

//--- verilog/centipede_io_cfg.svh
// centipede cabinet i/o configuration: widths, depths and memory map bases
`ifndef CENTIPEDE_IO_CFG_SVH
`define CENTIPEDE_IO_CFG_SVH

// bus side widths
`define CENT_ADDR_W 14
`define CENT_DATA_W 8
`define CENT_RESP_W 2

// cabinet side widths
`define CENT_SW_W 8
`define CENT_PLAYER_W 10
`define CENT_LED_W 4
`define CENT_COIN_W 3

// high score earom, 64 bytes
`define CENT_EAROM_AW 6
`define CENT_EAROM_DEPTH 64
`define CENT_EAROM_CTRL_W 4

// region bases in the 14-bit centipede map
`define CENT_OFS_SWITCH 'h0800
`define CENT_OFS_INPUT 'h0C00
`define CENT_OFS_EAROM_RD 'h1600
`define CENT_OFS_EAROM_CTRL 'h1680
`define CENT_OFS_EAROM_ADDR 'h1700
`define CENT_OFS_OUTLATCH 'h1C00

`endif
